/* rd_data_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module rd_data_fifo (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire fifo_reset_i,
	input wire read_enable_i,
	input wire rd_pkg::group_data_t wr_data_i,
	output rd_pkg::group_data_t rd_data_o
);
	import rd_pkg::*;

	// Flop storage for one DQS group, both time slots per entry
	group_data_t fifo_mem [READ_FIFO_DEPTH];

	fifo_addr_t wr_ptr;
	fifo_addr_t rd_ptr;

	// Entries written since the last reset and not yet read
	fifo_count_t fill_count;

	// *********************************************************
	// Storage
	// *********************************************************

	// The capture word lands every cycle, whether or not a read is pending
	// Nothing is written on a sequencer reset so the ring starts clean
	always_ff @(posedge pll_afi_clk)
	begin
		if (!fifo_reset_i)
		begin
			fifo_mem[wr_ptr] <= wr_data_i;
		end
	end

	// Read side is a plain mux on the read pointer
	assign rd_data_o = fifo_mem[rd_ptr];

	// *********************************************************
	// Pointers
	// *********************************************************

	// Pointers wrap on their own because the depth is a power of two
	// The sequencer reset lines the two pointers up again during calibration
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (fifo_reset_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			wr_ptr <= wr_ptr + fifo_addr_t'(1);
			if (read_enable_i)
			begin
				rd_ptr <= rd_ptr + fifo_addr_t'(1);
			end
		end
	end

	// Occupancy grows by one on every cycle without a read
	// Once the ring is full the oldest entry is overwritten and the count holds
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			fill_count <= '0;
		end
		else if (fifo_reset_i)
		begin
			fill_count <= '0;
		end
		else if (!read_enable_i && (fill_count != fifo_count_t'(READ_FIFO_DEPTH)))
		begin
			fill_count <= fill_count + fifo_count_t'(1);
		end
	end

	// *********************************************************
	// Checks
	// *********************************************************

	// A read on an empty ring would hand out the entry that the write side
	// is only now filling, so the read pointer would overtake the write pointer
	a_read_not_empty: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(read_enable_i && !fifo_reset_i) |-> (fill_count != '0)
	)
	else
		$error("read FIFO read while no entry was written since its reset");

endmodule

`default_nettype wire

/* rd_latency_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module rd_latency_decoder (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire afi_rdata_en_i,
	input wire afi_rdata_en_full_i,
	input wire rd_pkg::lat_count_t seq_read_latency_counter_i,
	output logic read_enable_o,
	output logic read_valid_o,
	output rd_pkg::dqs_mask_t force_oct_off_o
);
	import rd_pkg::*;

	// Bit k holds the strobe sampled k+1 edges ago
	logic [MAX_READ_LATENCY-1:0] valid_shifter;
	logic [MAX_READ_LATENCY-1:0] enable_shifter;

	// Latency setting turned into a shifter tap
	lat_count_t lat_minus_one;
	logic [LAT_TAP_WIDTH-1:0] tap_sel;

	// Recent history of the full strobe for the termination window
	logic [OCT_OFF_DELAY-1:0] oct_history;
	logic [OCT_OFF_DELAY:0] oct_taps;

	// *********************************************************
	// Latency shifters
	// *********************************************************

	// Both strobes march through their own shifter one bit per cycle
	// A strobe sampled at edge N sits in bit k after edge N+k
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			valid_shifter <= '0;
			enable_shifter <= '0;
		end
		else
		begin
			valid_shifter <= {valid_shifter[MAX_READ_LATENCY-2:0], afi_rdata_en_i};
			enable_shifter <= {enable_shifter[MAX_READ_LATENCY-2:0], afi_rdata_en_full_i};
		end
	end

	// A setting of L picks bit L-1, so the strobe shows up in the
	// cycle that ends at edge N+L
	assign lat_minus_one = seq_read_latency_counter_i - lat_count_t'(1);
	// Legal settings are 1 to 16, which fit the low four bits after the decrement
	assign tap_sel = lat_minus_one[LAT_TAP_WIDTH-1:0];

	// One tap serves every group since all groups share the AFI clock
	assign read_valid_o = valid_shifter[tap_sel];
	assign read_enable_o = enable_shifter[tap_sel];

	// *********************************************************
	// Termination window
	// *********************************************************

	// Bit 0 is the strobe being sampled now, bit j the one from j edges back
	assign oct_taps = {oct_history, afi_rdata_en_full_i};

	// Termination must stay on while read data may still be on the bus
	// Any full strobe seen in the window keeps force_oct_off low
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			oct_history <= '0;
			force_oct_off_o <= '0;
		end
		else
		begin
			oct_history <= {oct_history[OCT_OFF_DELAY-2:0], afi_rdata_en_full_i};
			// Window covers the strobes from OCT_OFF_DELAY down to OCT_ON_DELAY edges back
			force_oct_off_o <= {MEM_READ_DQS_WIDTH{~(|oct_taps[OCT_OFF_DELAY:OCT_ON_DELAY])}};
		end
	end

	// *********************************************************
	// Checks
	// *********************************************************

	// The sequencer has to set a latency before the controller issues reads
	// A zero setting would alias onto the last tap and return data 16 cycles late
	a_latency_set: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(afi_rdata_en_i || afi_rdata_en_full_i) |-> (seq_read_latency_counter_i != '0)
	)
	else
		$error("read strobe sampled with a zero read latency setting");

endmodule

`default_nettype wire

/* rd_pkg.sv */
`default_nettype none

package rd_pkg;

	// *********************************************************
	// Memory-side geometry
	// *********************************************************

	// Data pins on the memory interface
	localparam int MEM_DQ_WIDTH = 8;
	// Read DQS groups, each with its own capture FIFO
	localparam int MEM_READ_DQS_WIDTH = 2;
	// Pins owned by one DQS group
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / MEM_READ_DQS_WIDTH;

	// Full rate with DDR capture gives two data words per AFI cycle
	localparam int NUM_TIMESLOTS = 2;
	// One group's capture word, slot 1 above slot 0
	localparam int DDIO_GROUP_WIDTH = DQ_GROUP_WIDTH * NUM_TIMESLOTS;
	// Controller data bus
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// *********************************************************
	// Read FIFO and latency FIFO sizing
	// *********************************************************

	// Depth is a power of two so the pointers wrap by themselves
	localparam int READ_FIFO_DEPTH = 8;
	localparam int READ_FIFO_ADDR_WIDTH = 3;

	// Longest latency the sequencer may dial in, in AFI cycles
	localparam int MAX_READ_LATENCY = 16;
	localparam int MAX_LATENCY_COUNT_WIDTH = 5;
	// Tap index into the latency shifters
	localparam int LAT_TAP_WIDTH = $clog2(MAX_READ_LATENCY);

	// *********************************************************
	// On-die termination window
	// *********************************************************

	// Memory read latency in memory clocks
	localparam int MEM_T_RL = 6;
	// Termination is held from ON_DELAY to OFF_DELAY cycles after a read
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// Bus types
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
	typedef logic [DDIO_GROUP_WIDTH-1:0] group_data_t;
	typedef logic [MEM_READ_DQS_WIDTH-1:0] dqs_mask_t;
	typedef logic [MAX_LATENCY_COUNT_WIDTH-1:0] lat_count_t;
	typedef logic [READ_FIFO_ADDR_WIDTH-1:0] fifo_addr_t;
	// Occupancy needs one bit more than a pointer to hold a full ring
	typedef logic [READ_FIFO_ADDR_WIDTH:0] fifo_count_t;

endpackage

`default_nettype wire

/* rd_result_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module rd_result_stage (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire read_valid_i,
	input wire rd_pkg::group_data_t group_rdata_i [rd_pkg::MEM_READ_DQS_WIDTH],
	output rd_pkg::afi_data_t afi_rdata_o,
	output rd_pkg::afi_data_t phy_mux_read_fifo_q_o,
	output logic afi_rdata_valid_o
);
	import rd_pkg::*;

	// *********************************************************
	// Data mapping
	// *********************************************************

	// Controller bus is ordered by time slot, then by group
	//   G1_T1, G0_T1, G1_T0, G0_T0
	// Each FIFO word is ordered by slot within its own group
	always_comb
	begin
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin
			for (int t = 0; t < NUM_TIMESLOTS; t++)
			begin
				afi_rdata_o[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
					group_rdata_i[g][t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			end
		end
	end

	// Sequencer copy is ordered by group, then by time slot
	//   G1_T1, G1_T0, G0_T1, G0_T0
	// It is unpicked from the controller bus so both views stay in step
	always_comb
	begin
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin
			for (int t = 0; t < NUM_TIMESLOTS; t++)
			begin
				phy_mux_read_fifo_q_o[g*DDIO_GROUP_WIDTH + t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
					afi_rdata_o[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			end
		end
	end

	// *********************************************************
	// Data valid
	// *********************************************************

	// Valid is registered on the AFI clock, one cycle after the tap fires
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_valid_o <= 1'b0;
		end
		else
		begin
			afi_rdata_valid_o <= read_valid_i;
		end
	end

endmodule

`default_nettype wire

/* read_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module read_datapath (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire afi_rdata_en_i,
	input wire afi_rdata_en_full_i,
	input wire rd_pkg::lat_count_t seq_read_latency_counter_i,
	input wire rd_pkg::dqs_mask_t seq_read_fifo_reset_i,
	input wire [rd_pkg::MEM_READ_DQS_WIDTH*rd_pkg::DDIO_GROUP_WIDTH-1:0] ddio_phy_dq_i,
	output rd_pkg::afi_data_t afi_rdata_o,
	output rd_pkg::afi_data_t phy_mux_read_fifo_q_o,
	output logic afi_rdata_valid_o,
	output rd_pkg::dqs_mask_t force_oct_off_o
);
	import rd_pkg::*;

	// Delayed strobes from the latency decoder
	logic read_enable;
	logic read_valid;

	// Read FIFO output word of every DQS group
	group_data_t group_rdata [MEM_READ_DQS_WIDTH];

	// *********************************************************
	// Latency and termination
	// *********************************************************

	rd_latency_decoder u_rd_latency_decoder (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.read_enable_o              (read_enable),
		.read_valid_o               (read_valid),
		.force_oct_off_o            (force_oct_off_o)
	);

	// *********************************************************
	// Per-group read FIFOs
	// *********************************************************

	// Capture bus is ordered by group, so each FIFO takes one contiguous slice
	// Each group is reset on its own while the sequencer calibrates it
	for (genvar g = 0; g < MEM_READ_DQS_WIDTH; g++)
	begin : g_dqs_group
		rd_data_fifo u_rd_data_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.fifo_reset_i    (seq_read_fifo_reset_i[g]),
			.read_enable_i   (read_enable),
			.wr_data_i       (ddio_phy_dq_i[g*DDIO_GROUP_WIDTH +: DDIO_GROUP_WIDTH]),
			.rd_data_o       (group_rdata[g])
		);
	end

	// *********************************************************
	// Output mapping
	// *********************************************************

	rd_result_stage u_rd_result_stage (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.read_valid_i          (read_valid),
		.group_rdata_i         (group_rdata),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the read datapath testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f vlog.f --top-module tb_read_datapath -Mdir obj_dir -o sim_read_datapath
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_read_datapath > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The run passes only if the testbench reported success
if grep -q "^Test completed successfully$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tb_rd_ref.svh */
// *********************************************************
// Stimulus source
// *********************************************************

// Right-shifting Galois LFSR with taps 32, 30, 26 and 25
logic [31:0] lfsr_state = 32'h172e_816f;

// Each call steps the register once and hands out the bit shifted out
function automatic logic lfsr_bit();
	logic out_bit;
	out_bit = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (out_bit)
	begin
		lfsr_state = lfsr_state ^ 32'hA300_0000;
	end
	return out_bit;
endfunction

// A full capture word, built one LFSR bit at a time
function automatic afi_data_t lfsr_word();
	afi_data_t word;
	for (int i = 0; i < AFI_DATA_WIDTH; i++)
	begin
		word = {word[AFI_DATA_WIDTH-2:0], lfsr_bit()};
	end
	return word;
endfunction

// *********************************************************
// Reference model
// *********************************************************

// Index k of a history holds the strobe sampled k edges back
logic [MAX_READ_LATENCY:0] en_hist;
logic [MAX_READ_LATENCY:0] full_hist;
group_data_t model_mem [MEM_READ_DQS_WIDTH][READ_FIFO_DEPTH];
bit model_written [MEM_READ_DQS_WIDTH][READ_FIFO_DEPTH];
fifo_addr_t model_wr [MEM_READ_DQS_WIDTH];
fifo_addr_t model_rd [MEM_READ_DQS_WIDTH];
logic exp_valid;
dqs_mask_t exp_oct_off;

// Advances the model by one rising edge with the inputs sampled there
function automatic void model_edge(input logic rst_n, input logic en, input logic full,
	input lat_count_t lat, input dqs_mask_t frst, input afi_data_t dq);
	logic rd_step;
	// Reset holds the strobe histories, the pointers and the outputs at zero
	if (!rst_n)
	begin
		en_hist = '0;
		full_hist = '0;
		exp_valid = 1'b0;
		exp_oct_off = '0;
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin
			model_wr[g] = '0;
			model_rd[g] = '0;
		end
	end
	// Storage itself has no reset, so the word still lands at the write pointer
	for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
	begin
		if (!frst[g])
		begin
			model_mem[g][model_wr[g]] = dq[g*DDIO_GROUP_WIDTH +: DDIO_GROUP_WIDTH];
			model_written[g][model_wr[g]] = 1'b1;
		end
	end
	if (rst_n)
	begin
		en_hist = {en_hist[MAX_READ_LATENCY-1:0], en};
		full_hist = {full_hist[MAX_READ_LATENCY-1:0], full};
		// Valid and the read step both come from the strobe L edges back
		exp_valid = en_hist[lat];
		rd_step = full_hist[lat];
		// Termination is forced off only when no read fell in the last six edges
		exp_oct_off = {MEM_READ_DQS_WIDTH{~(|full_hist[6:1])}};
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin
			if (frst[g])
			begin
				model_wr[g] = '0;
				model_rd[g] = '0;
			end
			else
			begin
				model_wr[g] = model_wr[g] + fifo_addr_t'(1);
				if (rd_step)
				begin
					model_rd[g] = model_rd[g] + fifo_addr_t'(1);
				end
			end
		end
	end
endfunction

// Expected controller and sequencer words, with masks of the written entries
function automatic void expected_words(output afi_data_t afi, output afi_data_t afi_known,
	output afi_data_t seq, output afi_data_t seq_known);
	group_data_t entry;
	group_data_t known;
	for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
	begin
		entry = model_mem[g][model_rd[g]];
		known = {DDIO_GROUP_WIDTH{model_written[g][model_rd[g]]}};
		// Sequencer view keeps each group's two slots together
		seq[g*DDIO_GROUP_WIDTH +: DDIO_GROUP_WIDTH] = entry;
		seq_known[g*DDIO_GROUP_WIDTH +: DDIO_GROUP_WIDTH] = known;
		// Controller view puts slot t of group g at bit 8t+4g
		for (int t = 0; t < NUM_TIMESLOTS; t++)
		begin
			afi[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				entry[t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			afi_known[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				known[t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		end
	end
endfunction

/* tb_read_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_read_datapath;
	import rd_pkg::*;

	// Length of each part of the run in clock cycles
	localparam int RESET_CYCLES = 4;
	localparam int LAT_RUN_CYCLES = 64;
	localparam int DATA_RUN_CYCLES = 120;
	localparam int FRST_RUN_CYCLES = 30;
	// Quiet cycles ahead of a FIFO reset, one less than the latency of that test
	localparam int FRST_GAP_CYCLES = 3;
	localparam int DRAIN_CYCLES = 20;
	localparam int OCT_CYCLES = 81;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 3 * (LAT_RUN_CYCLES + DRAIN_CYCLES)
		+ DATA_RUN_CYCLES + DRAIN_CYCLES + 3 * FRST_RUN_CYCLES + 2 * (FRST_GAP_CYCLES + 1)
		+ DRAIN_CYCLES + OCT_CYCLES;
	// Half as much again as the stimulus needs
	localparam int TIMEOUT_CYCLES = TOTAL_CYCLES * 3 / 2;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	logic afi_rdata_en;
	logic afi_rdata_en_full;
	lat_count_t seq_read_latency_counter;
	dqs_mask_t seq_read_fifo_reset;
	afi_data_t ddio_phy_dq;
	afi_data_t afi_rdata;
	afi_data_t phy_mux_read_fifo_q;
	logic afi_rdata_valid;
	dqs_mask_t force_oct_off;

	string test_name;
	int valid_errors = 0;
	int data_errors = 0;
	int seq_errors = 0;
	int oct_errors = 0;
	int timeout_errors = 0;
	int cycle_count;

	`include "tb_rd_ref.svh"

	read_datapath dut (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en),
		.afi_rdata_en_full_i        (afi_rdata_en_full),
		.seq_read_latency_counter_i (seq_read_latency_counter),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.afi_rdata_o                (afi_rdata),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.force_oct_off_o            (force_oct_off)
	);

	// 50 MHz AFI clock
	initial pll_afi_clk = 1'b0;
	always #10 pll_afi_clk = ~pll_afi_clk;

	// *********************************************************
	// Stimulus helpers
	// *********************************************************

	// One cycle of stimulus applied on the falling edge, with fresh capture data
	task automatic drive_cycle(input logic en, input logic full, input dqs_mask_t frst);
		@(negedge pll_afi_clk);
		afi_rdata_en = en;
		afi_rdata_en_full = full;
		seq_read_fifo_reset = frst;
		ddio_phy_dq = lfsr_word();
	endtask

	task automatic drive_random(input int cycles);
		logic en;
		logic full;
		for (int i = 0; i < cycles; i++)
		begin
			en = lfsr_bit();
			full = lfsr_bit();
			drive_cycle(en, full, '0);
		end
	endtask

	// Idle cycles let every strobe in flight drain out of the latency shifters
	task automatic drive_idle(input int cycles);
		repeat (cycles)
			drive_cycle(1'b0, 1'b0, '0);
	endtask

	task automatic run_latency(input int lat);
		test_name = $sformatf("valid_latency_%0d", lat);
		seq_read_latency_counter = lat_count_t'(lat);
		drive_random(LAT_RUN_CYCLES);
		drive_idle(DRAIN_CYCLES);
	endtask

	// *********************************************************
	// Comparison
	// *********************************************************

	task automatic check_outputs();
		afi_data_t exp_afi;
		afi_data_t afi_known;
		afi_data_t exp_seq;
		afi_data_t seq_known;
		expected_words(exp_afi, afi_known, exp_seq, seq_known);
		assert (afi_rdata_valid === exp_valid)
		else
		begin
			valid_errors++;
			$display("[ERROR] %s: afi_rdata_valid_o expected %0b actual %0b",
				test_name, exp_valid, afi_rdata_valid);
		end
		// Slices from entries never written are masked out of the data compare
		assert ((afi_rdata & afi_known) === (exp_afi & afi_known))
		else
		begin
			data_errors++;
			$display("[ERROR] %s: afi_rdata_o expected %h actual %h",
				test_name, exp_afi & afi_known, afi_rdata & afi_known);
		end
		assert ((phy_mux_read_fifo_q & seq_known) === (exp_seq & seq_known))
		else
		begin
			seq_errors++;
			$display("[ERROR] %s: phy_mux_read_fifo_q_o expected %h actual %h",
				test_name, exp_seq & seq_known, phy_mux_read_fifo_q & seq_known);
		end
		assert (force_oct_off === exp_oct_off)
		else
		begin
			oct_errors++;
			$display("[ERROR] %s: force_oct_off_o expected %b actual %b",
				test_name, exp_oct_off, force_oct_off);
		end
	endtask

	// Inputs are stable at the rising edge, outputs have settled halfway to the falling edge
	always
	begin
		@(posedge pll_afi_clk);
		model_edge(reset_n_afi_clk, afi_rdata_en, afi_rdata_en_full,
			seq_read_latency_counter, seq_read_fifo_reset, ddio_phy_dq);
		#5;
		check_outputs();
	end

	task automatic finish_run();
		int total;
		total = valid_errors + data_errors + seq_errors + oct_errors + timeout_errors;
		$display("Errors: valid %0d, data %0d, sequencer data %0d, termination %0d, timeout %0d",
			valid_errors, data_errors, seq_errors, oct_errors, timeout_errors);
		if (total == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	endtask

	// Watchdog on the number of clock cycles
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge pll_afi_clk);
			cycle_count++;
		end
		timeout_errors++;
		$display("Timeout: the stimulus was still running after %0d clock cycles", cycle_count);
		finish_run();
	end

	// *********************************************************
	// Test sequence
	// *********************************************************

	initial
	begin
		test_name = "reset";
		reset_n_afi_clk = 1'b0;
		afi_rdata_en = 1'b0;
		afi_rdata_en_full = 1'b0;
		seq_read_latency_counter = lat_count_t'(1);
		seq_read_fifo_reset = '0;
		ddio_phy_dq = '0;
		repeat (RESET_CYCLES)
			@(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		reset_n_afi_clk = 1'b1;
		// Registered outputs still hold their reset values until the next edge
		#1;
		assert (afi_rdata_valid === 1'b0)
		else
		begin
			valid_errors++;
			$display("[ERROR] %s: afi_rdata_valid_o expected 0 actual %0b", test_name,
				afi_rdata_valid);
		end
		assert (force_oct_off === '0)
		else
		begin
			oct_errors++;
			$display("[ERROR] %s: force_oct_off_o expected 00 actual %b", test_name,
				force_oct_off);
		end

		run_latency(1);
		run_latency(5);
		run_latency(16);

		test_name = "read_data";
		seq_read_latency_counter = lat_count_t'(3);
		drive_random(DATA_RUN_CYCLES);
		drive_idle(DRAIN_CYCLES);

		// Each group is realigned on its own between bursts of reads
		// The quiet cycles keep a read off the edge right after the reset
		test_name = "fifo_reset";
		seq_read_latency_counter = lat_count_t'(4);
		drive_random(FRST_RUN_CYCLES);
		drive_idle(FRST_GAP_CYCLES);
		drive_cycle(1'b0, 1'b0, 2'b01);
		drive_random(FRST_RUN_CYCLES);
		drive_idle(FRST_GAP_CYCLES);
		drive_cycle(1'b0, 1'b0, 2'b10);
		drive_random(FRST_RUN_CYCLES);
		drive_idle(DRAIN_CYCLES);

		// Isolated reads, then bursts, then two reads whose windows overlap
		test_name = "oct_window";
		seq_read_latency_counter = lat_count_t'(6);
		repeat (3)
		begin
			drive_cycle(1'b1, 1'b1, '0);
			drive_idle(11);
		end
		repeat (2)
		begin
			repeat (4)
				drive_cycle(1'b1, 1'b1, '0);
			drive_idle(11);
		end
		drive_cycle(1'b1, 1'b1, '0);
		drive_idle(2);
		drive_cycle(1'b1, 1'b1, '0);
		drive_idle(11);

		finish_run();
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
rd_pkg.sv
rd_latency_decoder.sv
rd_data_fifo.sv
rd_result_stage.sv
read_datapath.sv
tb_read_datapath.sv
